//--- hw/chess_pkg.sv
`default_nettype none

package chess_pkg;

   typedef logic [3:0]  piece_t;      // Bit 3 colour (1 = Black), bits 2..0 kind
   typedef logic [2:0]  kind_t;
   typedef logic [5:0]  square_t;     // Rank * 8 + file, rank 0 is White's back rank
   typedef logic [31:0] axil_data_t;
   typedef logic [1:0]  axil_resp_t;

   localparam kind_t kind_empty  = 3'd0;   // Kind 7 also scores as empty
   localparam kind_t kind_pawn   = 3'd1;
   localparam kind_t kind_knight = 3'd2;
   localparam kind_t kind_bishop = 3'd3;
   localparam kind_t kind_rook   = 3'd4;
   localparam kind_t kind_queen  = 3'd5;
   localparam kind_t kind_king   = 3'd6;

   localparam piece_t empty_piece  = 4'h0;
   localparam piece_t white_pawn   = 4'h1;
   localparam piece_t white_knight = 4'h2;
   localparam piece_t white_bishop = 4'h3;
   localparam piece_t white_rook   = 4'h4;
   localparam piece_t white_queen  = 4'h5;
   localparam piece_t white_king   = 4'h6;
   localparam piece_t black_pawn   = 4'h9;
   localparam piece_t black_knight = 4'ha;
   localparam piece_t black_bishop = 4'hb;
   localparam piece_t black_rook   = 4'hc;
   localparam piece_t black_queen  = 4'hd;
   localparam piece_t black_king   = 4'he;

   localparam int pawn_value         = 100;
   localparam int knight_value       = 300;
   localparam int bishop_value       = 320;
   localparam int rook_value         = 500;
   localparam int queen_value        = 900;
   localparam int king_value         = 0;
   localparam int pawn_advance_bonus = 10;   // Per rank past the pawn's home rank

   localparam int reg_board_base = 'h000;    // One word per square
   localparam int board_span     = 'h100;    // 64 squares * 4 bytes
   localparam int reg_ctrl       = 'h100;    // Write only
   localparam int reg_status     = 'h104;
   localparam int reg_eval       = 'h108;

   localparam int ctrl_start_bit = 0;
   localparam int ctrl_load_bit  = 1;
   localparam int ctrl_clear_bit = 2;

   localparam axil_resp_t resp_okay   = 2'b00;
   localparam axil_resp_t resp_slverr = 2'b10;

endpackage

`default_nettype wire

//--- hw/chess_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module chess_axil_regs
#(
   parameter int EVAL_WIDTH      = 22,
   parameter int AXIL_ADDR_WIDTH = 12
)
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic [AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr,
   input  logic                         s_axil_awvalid,
   output logic                         s_axil_awready,
   input  chess_pkg::axil_data_t        s_axil_wdata,
   input  logic [3:0]                   s_axil_wstrb,      // Full-word writes only, not decoded
   input  logic                         s_axil_wvalid,
   output logic                         s_axil_wready,
   output chess_pkg::axil_resp_t        s_axil_bresp,
   output logic                         s_axil_bvalid,
   input  logic                         s_axil_bready,
   input  logic [AXIL_ADDR_WIDTH-1:0]   s_axil_araddr,
   input  logic                         s_axil_arvalid,
   output logic                         s_axil_arready,
   output chess_pkg::axil_data_t        s_axil_rdata,
   output chess_pkg::axil_resp_t        s_axil_rresp,
   output logic                         s_axil_rvalid,
   input  logic                         s_axil_rready,
   output logic                         host_we,
   output chess_pkg::square_t           host_addr,
   output chess_pkg::piece_t            host_wdata,
   output logic                         load_start,
   output logic                         clear_board,
   output logic                         eval_start,
   input  chess_pkg::piece_t            host_rdata,
   input  logic                         eval_busy,
   input  logic                         eval_done,
   input  logic signed [EVAL_WIDTH-1:0] eval_score,
   input  logic                         white_king,
   input  logic                         black_king
);
   import chess_pkg::*;

   typedef enum logic {wr_idle, wr_resp} wr_state_t;
   typedef enum logic [1:0] {rd_idle, rd_wait, rd_resp} rd_state_t;

   wr_state_t                  wr_state;
   rd_state_t                  rd_state;
   logic                       wr_go;       // AW and W both pending, accept next cycle
   logic                       wr_fire;     // Write handshake cycle
   logic                       rd_go;
   logic                       aw_board;
   logic                       aw_ctrl;
   logic                       wr_ok;       // Write lands somewhere writable
   logic                       cmd_fire;    // Accepted write to the command register
   logic [AXIL_ADDR_WIDTH-1:0] ar_q;        // Read address held for the data stage
   axil_data_t                 rd_mux;
   logic                       rd_err;

   function automatic logic in_board(input logic [AXIL_ADDR_WIDTH-1:0] a);
      return int'(a) >= reg_board_base && int'(a) < reg_board_base + board_span;
   endfunction

   function automatic square_t square_of(input logic [AXIL_ADDR_WIDTH-1:0] a);
      return square_t'((int'(a) - reg_board_base) >> 2);   // Byte offset to word index
   endfunction

   // Write decode, valid during the awready cycle
   assign wr_go    = wr_state == wr_idle && !s_axil_awready && s_axil_awvalid && s_axil_wvalid;
   assign wr_fire  = s_axil_awready;                // Master holds valid until accepted
   assign aw_board = in_board(s_axil_awaddr);
   assign aw_ctrl  = int'(s_axil_awaddr) == reg_ctrl;
   assign wr_ok    = (aw_board || aw_ctrl) && !eval_busy;   // Board frozen during a scan
   assign cmd_fire = wr_fire && aw_ctrl && !eval_busy;

   assign host_we     = wr_fire && aw_board && !eval_busy;
   assign host_wdata  = s_axil_wdata[3:0];
   assign clear_board = cmd_fire && s_axil_wdata[ctrl_clear_bit];
   assign load_start  = cmd_fire && s_axil_wdata[ctrl_load_bit];    // Board applies after clear
   assign eval_start  = cmd_fire && s_axil_wdata[ctrl_start_bit];

   // Shared board port, write wins since accepts never overlap
   assign host_addr = wr_fire ? square_of(s_axil_awaddr) : square_of(s_axil_araddr);

   // Read accept yields to a write accept in the same cycle
   assign rd_go = rd_state == rd_idle && !s_axil_arready && s_axil_arvalid && !wr_go;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_state       <= wr_idle;
         s_axil_awready <= 1'b0;
         s_axil_wready  <= 1'b0;
         s_axil_bvalid  <= 1'b0;
      end
      else
      begin
         case (wr_state)
            wr_idle:
            begin
               if (wr_go)
               begin
                  s_axil_awready <= 1'b1;   // One-cycle accept pulse
                  s_axil_wready  <= 1'b1;
               end
               else if (wr_fire)
               begin
                  s_axil_awready <= 1'b0;
                  s_axil_wready  <= 1'b0;
                  s_axil_bvalid  <= 1'b1;
                  wr_state       <= wr_resp;
               end
            end
            wr_resp:
            begin
               if (s_axil_bready)
               begin
                  s_axil_bvalid <= 1'b0;
                  wr_state      <= wr_idle;
               end
            end
            default: wr_state <= wr_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_fire)
         s_axil_bresp <= wr_ok ? resp_okay : resp_slverr;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rd_state       <= rd_idle;
         s_axil_arready <= 1'b0;
         s_axil_rvalid  <= 1'b0;
      end
      else
      begin
         case (rd_state)
            rd_idle:
            begin
               if (rd_go)
                  s_axil_arready <= 1'b1;
               else if (s_axil_arready)
               begin
                  s_axil_arready <= 1'b0;
                  rd_state       <= rd_wait;   // Board read in flight
               end
            end
            rd_wait:
            begin
               s_axil_rvalid <= 1'b1;
               rd_state      <= rd_resp;
            end
            rd_resp:
            begin
               if (s_axil_rready)
               begin
                  s_axil_rvalid <= 1'b0;
                  rd_state      <= rd_idle;
               end
            end
            default: rd_state <= rd_idle;
         endcase
      end
   end

   // Read mux, host_rdata is the square addressed in the accept cycle
   always_comb
   begin
      rd_mux = '0;
      rd_err = 1'b0;
      if (in_board(ar_q))
         rd_mux = axil_data_t'(host_rdata);
      else if (int'(ar_q) == reg_status)
         rd_mux = axil_data_t'({black_king, white_king, eval_done, eval_busy});
      else if (int'(ar_q) == reg_eval)
         rd_mux = 32'(eval_score);                // Sign extended
      else if (int'(ar_q) != reg_ctrl)
         rd_err = 1'b1;                           // Unmapped, data stays 0
   end

   always_ff @(posedge clk)
   begin
      if (s_axil_arready)
         ar_q <= s_axil_araddr;
      if (rd_state == rd_wait)
      begin
         s_axil_rdata <= rd_mux;
         s_axil_rresp <= rd_err ? resp_slverr : resp_okay;
      end
   end

endmodule

`default_nettype wire

//--- hw/board_store.sv
`timescale 1ns/1ps
`default_nettype none

module board_store
(
   input  logic               clk,
   input  logic               rst,
   input  logic               host_we,
   input  chess_pkg::square_t host_addr,
   input  chess_pkg::piece_t  host_wdata,
   input  logic               load_start,
   input  logic               clear_board,
   input  chess_pkg::square_t scan_addr,
   output chess_pkg::piece_t  host_rdata,
   output chess_pkg::piece_t  scan_piece
);
   import chess_pkg::*;

   piece_t board [64];

   // Standard opening layout for one square
   function automatic piece_t start_piece(input square_t sq);
      piece_t back [8];
      back = '{white_rook, white_knight, white_bishop, white_queen,
               white_king, white_bishop, white_knight, white_rook};
      case (sq[5:3])
         3'd0:    return back[sq[2:0]];
         3'd1:    return white_pawn;
         3'd6:    return black_pawn;
         3'd7:    return back[sq[2:0]] | 4'h8;   // Same pieces, colour bit set
         default: return empty_piece;
      endcase
   endfunction

   always_ff @(posedge clk)
   begin
      if (rst || clear_board)
      begin
         for (int i = 0; i < 64; i++)
            board[i] <= empty_piece;
      end
      else if (host_we)
         board[host_addr] <= host_wdata;
      if (load_start && !rst)                      // Overrides a clear in the same cycle
      begin
         for (int i = 0; i < 64; i++)
            board[i] <= start_piece(square_t'(i));
      end
   end

   // Two synchronous read ports
   always_ff @(posedge clk)
   begin
      host_rdata <= board[host_addr];
      scan_piece <= board[scan_addr];
   end

endmodule

`default_nettype wire

//--- hw/material_eval.sv
`timescale 1ns/1ps
`default_nettype none

module material_eval
#(
   parameter int EVAL_WIDTH = 22
)
(
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         eval_start,
   input  chess_pkg::piece_t            scan_piece,
   output chess_pkg::square_t           scan_addr,
   output logic                         eval_busy,
   output logic                         eval_done,
   output logic signed [EVAL_WIDTH-1:0] eval_score,
   output logic                         white_king,
   output logic                         black_king
);
   import chess_pkg::*;

   typedef enum logic [1:0] {ev_idle, ev_scan, ev_finish} ev_state_t;

   ev_state_t                    state;
   square_t                      addr_d;        // Square of the piece now on scan_piece
   logic                         piece_valid;   // scan_piece belongs to this scan
   kind_t                        kind;
   logic                         is_black;
   int                           rank;
   int                           pawn_steps;    // Ranks advanced from the home rank
   logic signed [EVAL_WIDTH-1:0] mag;           // Value plus bonus, before colour
   logic signed [EVAL_WIDTH-1:0] term;

   assign kind       = scan_piece[2:0];
   assign is_black   = scan_piece[3];
   assign rank       = int'(addr_d[5:3]);
   assign pawn_steps = is_black ? 6 - rank : rank - 1;   // Negative off the usual ranks

   always_comb
   begin
      case (kind)
         kind_pawn:   mag = EVAL_WIDTH'(pawn_value + pawn_advance_bonus * pawn_steps);
         kind_knight: mag = EVAL_WIDTH'(knight_value);
         kind_bishop: mag = EVAL_WIDTH'(bishop_value);
         kind_rook:   mag = EVAL_WIDTH'(rook_value);
         kind_queen:  mag = EVAL_WIDTH'(queen_value);
         kind_king:   mag = EVAL_WIDTH'(king_value);
         kind_empty:  mag = '0;
         default:     mag = '0;                  // Kind 7 scores as empty
      endcase
      term = is_black ? -mag : mag;              // White's point of view
   end

   always_ff @(posedge clk)
   begin
      addr_d <= scan_addr;                       // Lines up with the read latency
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state       <= ev_idle;
         scan_addr   <= '0;
         piece_valid <= 1'b0;
         eval_busy   <= 1'b0;
         eval_done   <= 1'b0;
         eval_score  <= '0;
         white_king  <= 1'b0;
         black_king  <= 1'b0;
      end
      else
      begin
         piece_valid <= state == ev_scan;
         if (piece_valid)
         begin
            eval_score <= eval_score + term;
            if (kind == kind_king)
            begin
               if (is_black)
                  black_king <= 1'b1;
               else
                  white_king <= 1'b1;
            end
         end
         case (state)
            ev_idle:
            begin
               if (eval_start)
               begin
                  state      <= ev_scan;
                  scan_addr  <= '0;
                  eval_busy  <= 1'b1;
                  eval_done  <= 1'b0;
                  eval_score <= '0;              // Old results drop here
                  white_king <= 1'b0;
                  black_king <= 1'b0;
               end
            end
            ev_scan:
            begin
               scan_addr <= scan_addr + 1'b1;
               if (scan_addr == 6'd63)
                  state <= ev_finish;            // Last read issued
            end
            ev_finish:
            begin
               state     <= ev_idle;             // Square 63 accumulates this cycle
               eval_busy <= 1'b0;
               eval_done <= 1'b1;
            end
            default: state <= ev_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/vchess_top.sv
`timescale 1ns/1ps
`default_nettype none

module vchess_top
#(
   parameter int EVAL_WIDTH      = 22,       // Worst case score needs 15 bits
   parameter int AXIL_ADDR_WIDTH = 12
)
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic [AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
   input  logic                       s_axil_awvalid,
   output logic                       s_axil_awready,
   input  chess_pkg::axil_data_t      s_axil_wdata,
   input  logic [3:0]                 s_axil_wstrb,
   input  logic                       s_axil_wvalid,
   output logic                       s_axil_wready,
   output chess_pkg::axil_resp_t      s_axil_bresp,
   output logic                       s_axil_bvalid,
   input  logic                       s_axil_bready,
   input  logic [AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
   input  logic                       s_axil_arvalid,
   output logic                       s_axil_arready,
   output chess_pkg::axil_data_t      s_axil_rdata,
   output chess_pkg::axil_resp_t      s_axil_rresp,
   output logic                       s_axil_rvalid,
   input  logic                       s_axil_rready
);
   import chess_pkg::*;

   logic                         host_we;
   square_t                      host_addr;
   piece_t                       host_wdata;
   piece_t                       host_rdata;
   logic                         load_start;
   logic                         clear_board;
   logic                         eval_start;
   logic                         eval_busy;
   logic                         eval_done;
   logic signed [EVAL_WIDTH-1:0] eval_score;
   logic                         white_king;
   logic                         black_king;
   square_t                      scan_addr;     // Scanner's board read port
   piece_t                       scan_piece;

   chess_axil_regs
   #(
      .EVAL_WIDTH      (EVAL_WIDTH),
      .AXIL_ADDR_WIDTH (AXIL_ADDR_WIDTH)
   )
   chess_axil_regs_i
   (
      .clk            (clk),
      .rst            (rst),
      .s_axil_awaddr  (s_axil_awaddr),
      .s_axil_awvalid (s_axil_awvalid),
      .s_axil_awready (s_axil_awready),
      .s_axil_wdata   (s_axil_wdata),
      .s_axil_wstrb   (s_axil_wstrb),
      .s_axil_wvalid  (s_axil_wvalid),
      .s_axil_wready  (s_axil_wready),
      .s_axil_bresp   (s_axil_bresp),
      .s_axil_bvalid  (s_axil_bvalid),
      .s_axil_bready  (s_axil_bready),
      .s_axil_araddr  (s_axil_araddr),
      .s_axil_arvalid (s_axil_arvalid),
      .s_axil_arready (s_axil_arready),
      .s_axil_rdata   (s_axil_rdata),
      .s_axil_rresp   (s_axil_rresp),
      .s_axil_rvalid  (s_axil_rvalid),
      .s_axil_rready  (s_axil_rready),
      .host_we        (host_we),
      .host_addr      (host_addr),
      .host_wdata     (host_wdata),
      .load_start     (load_start),
      .clear_board    (clear_board),
      .eval_start     (eval_start),
      .host_rdata     (host_rdata),
      .eval_busy      (eval_busy),
      .eval_done      (eval_done),
      .eval_score     (eval_score),
      .white_king     (white_king),
      .black_king     (black_king)
   );

   board_store board_store_i
   (
      .clk         (clk),
      .rst         (rst),
      .host_we     (host_we),
      .host_addr   (host_addr),
      .host_wdata  (host_wdata),
      .load_start  (load_start),
      .clear_board (clear_board),
      .scan_addr   (scan_addr),
      .host_rdata  (host_rdata),
      .scan_piece  (scan_piece)
   );

   material_eval
   #(
      .EVAL_WIDTH (EVAL_WIDTH)
   )
   material_eval_i
   (
      .clk        (clk),
      .rst        (rst),
      .eval_start (eval_start),
      .scan_piece (scan_piece),
      .scan_addr  (scan_addr),
      .eval_busy  (eval_busy),
      .eval_done  (eval_done),
      .eval_score (eval_score),
      .white_king (white_king),
      .black_king (black_king)
   );

endmodule

`default_nettype wire

//--- testbench/vchess_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module vchess_asserts
(
   input logic        clk,
   input logic        rst,
   input logic        bvalid,
   input logic        bready,
   input logic [1:0]  bresp,
   input logic        rvalid,
   input logic        rready,
   input logic [31:0] rdata,
   input logic [1:0]  rresp,
   input logic        eval_start,
   input logic        eval_busy,
   input logic        eval_done
);

   bresp_held: assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("bvalid dropped or bresp changed before bready");

   rdata_held: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else $error("rvalid dropped or read data changed before rready");

   done_not_busy: assert property (@(posedge clk) disable iff (rst)
      eval_done |-> !eval_busy)
      else $error("evaluator shows done and busy together");

   busy_follows_start: assert property (@(posedge clk) disable iff (rst)
      eval_start && !eval_busy |=> eval_busy)
      else $error("evaluator not busy the cycle after start");

   // 64 scan cycles plus the finish cycle
   busy_length: assert property (@(posedge clk) disable iff (rst)
      $fell(eval_busy) |-> $past(eval_busy, 65) && !$past(eval_busy, 66))
      else $error("evaluator busy period is not 65 cycles");

endmodule

bind chess_axil_regs vchess_asserts vchess_asserts_i
(
   .clk        (clk),
   .rst        (rst),
   .bvalid     (s_axil_bvalid),
   .bready     (s_axil_bready),
   .bresp      (s_axil_bresp),
   .rvalid     (s_axil_rvalid),
   .rready     (s_axil_rready),
   .rdata      (s_axil_rdata),
   .rresp      (s_axil_rresp),
   .eval_start (eval_start),
   .eval_busy  (eval_busy),
   .eval_done  (eval_done)
);

`default_nettype wire

//--- testbench/tb_vchess.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vchess;

   localparam int          max_cycles  = 20000;   // Run needs about 6000, random rounds dominate
   localparam logic [11:0] ctrl_addr   = 12'h100;
   localparam logic [11:0] status_addr = 12'h104;
   localparam logic [11:0] eval_addr   = 12'h108;

   logic        clk;
   logic        rst;
   logic [11:0] s_axil_awaddr;
   logic        s_axil_awvalid;
   logic        s_axil_awready;
   logic [31:0] s_axil_wdata;
   logic [3:0]  s_axil_wstrb;
   logic        s_axil_wvalid;
   logic        s_axil_wready;
   logic [1:0]  s_axil_bresp;
   logic        s_axil_bvalid;
   logic        s_axil_bready;
   logic [11:0] s_axil_araddr;
   logic        s_axil_arvalid;
   logic        s_axil_arready;
   logic [31:0] s_axil_rdata;
   logic [1:0]  s_axil_rresp;
   logic        s_axil_rvalid;
   logic        s_axil_rready;

   int mismatch_count = 0;
   int other_count    = 0;
   int cycle_count    = 0;
   bit slow_ready     = 1'b0;   // Random bready and rready delays

   vchess_top #(.EVAL_WIDTH(22), .AXIL_ADDR_WIDTH(12)) vchess_top_i
   (
      .clk            (clk),
      .rst            (rst),
      .s_axil_awaddr  (s_axil_awaddr),
      .s_axil_awvalid (s_axil_awvalid),
      .s_axil_awready (s_axil_awready),
      .s_axil_wdata   (s_axil_wdata),
      .s_axil_wstrb   (s_axil_wstrb),
      .s_axil_wvalid  (s_axil_wvalid),
      .s_axil_wready  (s_axil_wready),
      .s_axil_bresp   (s_axil_bresp),
      .s_axil_bvalid  (s_axil_bvalid),
      .s_axil_bready  (s_axil_bready),
      .s_axil_araddr  (s_axil_araddr),
      .s_axil_arvalid (s_axil_arvalid),
      .s_axil_arready (s_axil_arready),
      .s_axil_rdata   (s_axil_rdata),
      .s_axil_rresp   (s_axil_rresp),
      .s_axil_rvalid  (s_axil_rvalid),
      .s_axil_rready  (s_axil_rready)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;                         // 10 ns period

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == max_cycles)
      begin
         other_count++;
         $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
         $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic ready_delay();
      int delay;
      delay = slow_ready ? int'($urandom_range(0, 3)) : 0;
      repeat (delay) @(posedge clk);
   endtask

   task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
      @(posedge clk);
      s_axil_awaddr  <= addr;
      s_axil_awvalid <= 1'b1;
      s_axil_wdata   <= data;
      s_axil_wvalid  <= 1'b1;
      do @(posedge clk); while (!s_axil_awready);   // AW and W accepted together
      assert (s_axil_wready)
      else
      begin
         $display("wready not raised together with awready for address 0x%03h", addr);
         other_count++;
      end
      s_axil_awvalid <= 1'b0;
      s_axil_wvalid  <= 1'b0;
      ready_delay();
      s_axil_bready <= 1'b1;
      do @(posedge clk); while (!s_axil_bvalid);
      resp = s_axil_bresp;
      s_axil_bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      @(posedge clk);
      s_axil_araddr  <= addr;
      s_axil_arvalid <= 1'b1;
      do @(posedge clk); while (!s_axil_arready);
      s_axil_arvalid <= 1'b0;
      ready_delay();
      s_axil_rready <= 1'b1;
      do @(posedge clk); while (!s_axil_rvalid);
      data = s_axil_rdata;
      resp = s_axil_rresp;
      s_axil_rready <= 1'b0;
   endtask

   task automatic check_value(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
         mismatch_count++;
      end
   endtask

   task automatic write_expect(input string test, input logic [11:0] addr,
                               input logic [31:0] data, input logic [1:0] exp_resp);
      logic [1:0] resp;
      axil_write(addr, data, resp);
      check_value({test, " bresp"}, 32'(exp_resp), 32'(resp));
   endtask

   task automatic read_expect(input string test, input logic [11:0] addr,
                              input logic [1:0] exp_resp, input logic [31:0] exp_data);
      logic [31:0] data;
      logic [1:0]  resp;
      axil_read(addr, data, resp);
      check_value({test, " rresp"}, 32'(exp_resp), 32'(resp));
      check_value(test, exp_data, data);
   endtask

   task automatic wait_done();
      logic [31:0] status;
      logic [1:0]  resp;
      do
         axil_read(status_addr, status, resp);
      while (!status[1]);                        // Status bit 1 is done
   endtask

   // Material rule, White positive, pawns gain 10 per rank advanced
   function automatic int piece_score(input logic [3:0] piece, input int sq);
      int rank;
      int value;
      rank = sq / 8;
      case (piece[2:0])
         3'd1:    value = 100 + 10 * (piece[3] ? 6 - rank : rank - 1);
         3'd2:    value = 300;
         3'd3:    value = 320;
         3'd4:    value = 500;
         3'd5:    value = 900;
         default: value = 0;                     // Empty, king and kind 7
      endcase
      return piece[3] ? -value : value;
   endfunction

   task automatic random_round(input int round);
      int          score;
      logic [3:0]  piece;
      logic [31:0] kings;
      score = 0;
      kings = 32'h2;                             // Done expected after the scan
      for (int sq = 0; sq < 64; sq++)
      begin
         piece = 4'($urandom);
         write_expect($sformatf("rand%0d sq%0d", round, sq), 12'(sq * 4), 32'(piece), 2'b00);
         score += piece_score(piece, sq);
         if (piece == 4'h6)
            kings[2] = 1'b1;
         if (piece == 4'he)
            kings[3] = 1'b1;
      end
      write_expect($sformatf("rand%0d start", round), ctrl_addr, 32'h1, 2'b00);
      wait_done();
      read_expect($sformatf("rand%0d score", round), eval_addr, 2'b00, 32'(score));
      read_expect($sformatf("rand%0d status", round), status_addr, 2'b00, kings);
   endtask

   task automatic play_file();
      int          fd;
      int          n;
      string       line;
      string       op;
      string       test;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] expected;
      fd = $fopen("testbench/vchess_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open testbench/vchess_stimulus.txt, scripted tests not run");
         other_count++;
         return;
      end
      while (!$feof(fd))
      begin
         n = $fgets(line, fd);
         if (n == 0 || line.len() < 2 || line[0] == "#")
            continue;                            // Blank or comment line
         n = $sscanf(line, "%s %s %h %h %h", op, test, addr, data, expected);
         if (n != 5)
         begin
            $display("Stimulus line could not be parsed: %s", line);
            other_count++;
         end
         else if (op == "W")
            write_expect(test, addr[11:0], data, expected[1:0]);
         else if (op == "R")
            read_expect(test, addr[11:0], data[1:0], expected);
         else if (op == "E")
         begin
            wait_done();
            read_expect(test, addr[11:0], data[1:0], expected);
         end
         else
         begin
            $display("Unknown operation %s in stimulus line %s", op, test);
            other_count++;
         end
      end
      $fclose(fd);
   endtask

   initial
   begin
      void'($urandom(32'hdf9e));
      rst            = 1'b1;
      s_axil_awaddr  = '0;
      s_axil_awvalid = 1'b0;
      s_axil_wdata   = '0;
      s_axil_wstrb   = 4'hf;
      s_axil_wvalid  = 1'b0;
      s_axil_bready  = 1'b0;
      s_axil_araddr  = '0;
      s_axil_arvalid = 1'b0;
      s_axil_rready  = 1'b0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      read_expect("reset status", status_addr, 2'b00, 32'h0);
      read_expect("reset score", eval_addr, 2'b00, 32'h0);
      for (int sq = 0; sq < 64; sq++)
         read_expect($sformatf("reset sq%0d", sq), 12'(sq * 4), 2'b00, 32'h0);

      write_expect("load start", ctrl_addr, 32'h2, 2'b00);
      write_expect("start eval", ctrl_addr, 32'h1, 2'b00);
      wait_done();
      read_expect("start score", eval_addr, 2'b00, 32'h0);
      read_expect("start status", status_addr, 2'b00, 32'he);
      read_expect("start sq0", 12'h000, 2'b00, 32'h4);    // White rook
      read_expect("start sq4", 12'h010, 2'b00, 32'h6);    // White king
      read_expect("start sq60", 12'h0f0, 2'b00, 32'he);   // Black king

      play_file();

      for (int round = 0; round < 10; round++)
      begin
         slow_ready = round >= 5;                 // Second half with back-pressure
         random_round(round);
      end

      slow_ready = 1'b0;
      write_expect("busy setup", 12'h020, 32'h3, 2'b00);
      write_expect("busy start", ctrl_addr, 32'h1, 2'b00);
      write_expect("busy square", 12'h020, 32'h5, 2'b10);  // Board frozen mid scan
      write_expect("busy clear", ctrl_addr, 32'h4, 2'b10);
      write_expect("busy load", ctrl_addr, 32'h2, 2'b10);
      wait_done();
      read_expect("busy square kept", 12'h020, 2'b00, 32'h3);

      slow_ready = 1'b1;
      write_expect("clear board", ctrl_addr, 32'h4, 2'b00);
      write_expect("clear start", ctrl_addr, 32'h1, 2'b00);
      wait_done();
      read_expect("clear score", eval_addr, 2'b00, 32'h0);
      read_expect("clear status", status_addr, 2'b00, 32'h2);

      $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/vchess_stimulus.txt
# op name addr(hex) data(hex) expected(hex); W: data written, expected is bresp
# R and E: data is the expected rresp, expected is read data; E polls done first
W clear_a    100 00000004 0
W wpawn_r6   0c0 00000001 0
W wking_a    010 00000006 0
W bking_a    0f0 0000000e 0
W start_a    100 00000001 0
E score_a    108 0 00000096
R status_a   104 0 0000000e
R sq48_a     0c0 0 00000001
W clear_b    100 00000004 0
W wking_b    010 00000006 0
W bqueen_b   0ec 0000000d 0
W bpawn_r1   02c 00000009 0
W wkind7_b   080 00000007 0
W bkind7_b   084 0000000f 0
W start_b    100 00000001 0
E score_b    108 0 fffffbe6
R status_b   104 0 00000006
W unmapped_w 200 00000001 2
R unmapped_r 10c 2 00000000
R ctrl_read  100 0 00000000
W clear_load 100 00000006 0
W start_c    100 00000001 0
E score_c    108 0 00000000
R sq60_c     0f0 0 0000000e

//--- verilog.f
hw/chess_pkg.sv
hw/chess_axil_regs.sv
hw/board_store.sv
hw/material_eval.sv
hw/vchess_top.sv
testbench/vchess_asserts.sv
testbench/tb_vchess.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vchess testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_vchess -o vchess_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/vchess_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
